/* hdl/sram_pkg.sv */
package sram_pkg;

  // word address width of the sram chip
  localparam int addr_bits = 20;

  // data word width of the sram chip
  localparam int data_bits = 16;

  // one word address
  typedef logic [addr_bits-1:0] addr_t;

  // one data word
  typedef logic [data_bits-1:0] data_t;

  // owner of a request
  // used by the arbiter for grants and read routing
  typedef enum logic {
    client_a = 1'b0,
    client_b = 1'b1
  } client_t;

  // controller access sequencer
  // idle accepts a request, the other two last one cycle each
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_reading = 2'd1,
    st_writing = 2'd2
  } ctrl_state_t;

endpackage

/* hdl/sram_req_if.sv */
interface sram_req_if;

  // request side, driven by the arbiter
  logic               req_valid;
  logic               write;
  sram_pkg::addr_t    addr;
  sram_pkg::data_t    wdata;

  // response side, driven by the controller
  logic               req_ready;
  logic               rsp_valid;
  sram_pkg::data_t    rdata;

  // arbiter end of the channel
  modport requester (
    output req_valid, write, addr, wdata,
    input  req_ready, rsp_valid, rdata
  );

  // controller end of the channel
  modport server (
    input  req_valid, write, addr, wdata,
    output req_ready, rsp_valid, rdata
  );

endinterface

/* hdl/sram_arbiter.sv */
module sram_arbiter (
  input  logic              clk,
  input  logic              reset,
  // client a
  input  logic              a_req_valid,
  input  logic              a_write,
  input  sram_pkg::addr_t   a_addr,
  input  sram_pkg::data_t   a_wdata,
  output logic              a_req_ready,
  output logic              a_rsp_valid,
  output sram_pkg::data_t   a_rdata,
  // client b
  input  logic              b_req_valid,
  input  logic              b_write,
  input  sram_pkg::addr_t   b_addr,
  input  sram_pkg::data_t   b_wdata,
  output logic              b_req_ready,
  output logic              b_rsp_valid,
  output sram_pkg::data_t   b_rdata,
  // toward the controller
  sram_req_if.requester     bus
);

  // client served by the last transfer
  sram_pkg::client_t last_served;
  // client picked this cycle
  sram_pkg::client_t grant;
  // owner of the read accepted most recently
  sram_pkg::client_t rd_owner;
  // owner delayed one cycle so it lines up with rsp_valid
  sram_pkg::client_t rsp_owner;

  logic transfer;

  // round robin choice
  // on contention the client not served last wins
  always_comb begin
    if (a_req_valid && b_req_valid) begin
      grant = (last_served == sram_pkg::client_a) ? sram_pkg::client_b : sram_pkg::client_a;
    end else if (a_req_valid) begin
      grant = sram_pkg::client_a;
    end else begin
      grant = sram_pkg::client_b;
    end
  end

  // mux the granted client onto the channel
  assign bus.req_valid = a_req_valid || b_req_valid;
  assign bus.write     = (grant == sram_pkg::client_a) ? a_write : b_write;
  assign bus.addr      = (grant == sram_pkg::client_a) ? a_addr : b_addr;
  assign bus.wdata     = (grant == sram_pkg::client_a) ? a_wdata : b_wdata;

  // a client sees ready unless the other one holds the grant
  assign a_req_ready = bus.req_ready && (grant == sram_pkg::client_a || !b_req_valid);
  assign b_req_ready = bus.req_ready && (grant == sram_pkg::client_b || !a_req_valid);

  assign transfer = bus.req_valid && bus.req_ready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      last_served <= sram_pkg::client_b;
      rd_owner    <= sram_pkg::client_a;
      rsp_owner   <= sram_pkg::client_a;
    end else begin
      if (transfer) begin
        last_served <= grant;
        if (!bus.write) begin
          rd_owner <= grant;
        end
      end
      // response comes two edges after acceptance
      // a new read may be accepted on the second of them
      rsp_owner <= rd_owner;
    end
  end

  // response goes back only to its owner
  assign a_rsp_valid = bus.rsp_valid && (rsp_owner == sram_pkg::client_a);
  assign b_rsp_valid = bus.rsp_valid && (rsp_owner == sram_pkg::client_b);
  assign a_rdata     = (rsp_owner == sram_pkg::client_a) ? bus.rdata : '0;
  assign b_rdata     = (rsp_owner == sram_pkg::client_b) ? bus.rdata : '0;

endmodule

/* hdl/sram_controller.sv */
module sram_controller (
  input  logic              clk,
  input  logic              reset,
  sram_req_if.server        bus,
  // chip pins
  output sram_pkg::addr_t   sram_addr,
  inout  sram_pkg::data_t   sram_data,
  output logic              sram_we_n,
  output logic              sram_oe_n
);

  // each access takes two cycles
  //   edge N      accept, latch address and write data
  //   fall N      strobe goes low
  //   edge N+1    back to idle, ready again
  //   fall N+1    strobe released, read data captured
  //   edge N+2    rsp_valid for one cycle on a read

  sram_pkg::ctrl_state_t state;
  sram_pkg::ctrl_state_t next_state;

  logic            accept;
  sram_pkg::addr_t addr_q;
  sram_pkg::data_t wdata_q;
  sram_pkg::data_t rdata_q;

  // write data kept on the pins for the cycle after st_writing
  // so it is still there when we_n rises
  logic wr_hold;

  // set at the falling edge that ends a read strobe
  logic rd_done;
  logic rsp_valid_q;

  // only idle takes a new request
  assign bus.req_ready = (state == sram_pkg::st_idle);
  assign accept        = bus.req_valid && bus.req_ready;

  always_comb begin
    next_state = state;
    case (state)
      sram_pkg::st_idle: begin
        if (accept) begin
          next_state = bus.write ? sram_pkg::st_writing : sram_pkg::st_reading;
        end
      end
      // single cycle of strobe setup then return
      sram_pkg::st_reading: next_state = sram_pkg::st_idle;
      sram_pkg::st_writing: next_state = sram_pkg::st_idle;
      default: next_state = sram_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= sram_pkg::st_idle;
      wr_hold     <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      state       <= next_state;
      wr_hold     <= (state == sram_pkg::st_writing);
      // one cycle pulse, half a cycle after capture
      rsp_valid_q <= rd_done;
    end
  end

  // address and data stay put until the next accepted request
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= bus.addr;
      if (bus.write) begin
        wdata_q <= bus.wdata;
      end
    end
  end

  // strobes change on the falling edge
  // half a cycle of setup after edge N and half a cycle of hold after N+1
  always_ff @(negedge clk or posedge reset) begin
    if (reset) begin
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      rd_done   <= 1'b0;
    end else begin
      sram_we_n <= (state != sram_pkg::st_writing);
      sram_oe_n <= (state != sram_pkg::st_reading);
      // oe_n still low here means this edge ends the read
      rd_done   <= !sram_oe_n;
    end
  end

  // sample chip output while oe_n has been low for a full cycle
  always_ff @(negedge clk) begin
    if (!sram_oe_n) begin
      rdata_q <= sram_data;
    end
  end

  assign sram_addr = addr_q;

  // drive the bus only around a write strobe
  // released half a cycle after we_n rises
  assign sram_data = (state == sram_pkg::st_writing || wr_hold) ? wdata_q : 'z;

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rdata     = rdata_q;

endmodule

/* hdl/sram_subsystem.sv */
module sram_subsystem (
  input  logic              clk,
  input  logic              reset,
  // client a
  input  logic              a_req_valid,
  input  logic              a_write,
  input  sram_pkg::addr_t   a_addr,
  input  sram_pkg::data_t   a_wdata,
  output logic              a_req_ready,
  output logic              a_rsp_valid,
  output sram_pkg::data_t   a_rdata,
  // client b
  input  logic              b_req_valid,
  input  logic              b_write,
  input  sram_pkg::addr_t   b_addr,
  input  sram_pkg::data_t   b_wdata,
  output logic              b_req_ready,
  output logic              b_rsp_valid,
  output sram_pkg::data_t   b_rdata,
  // chip pins
  output sram_pkg::addr_t   sram_addr,
  inout  sram_pkg::data_t   sram_data,
  output logic              sram_we_n,
  output logic              sram_oe_n
);

  // single channel from the arbiter to the controller
  sram_req_if req_bus ();

  sram_arbiter i_arbiter (
    .clk         (clk),
    .reset       (reset),
    .a_req_valid (a_req_valid),
    .a_write     (a_write),
    .a_addr      (a_addr),
    .a_wdata     (a_wdata),
    .a_req_ready (a_req_ready),
    .a_rsp_valid (a_rsp_valid),
    .a_rdata     (a_rdata),
    .b_req_valid (b_req_valid),
    .b_write     (b_write),
    .b_addr      (b_addr),
    .b_wdata     (b_wdata),
    .b_req_ready (b_req_ready),
    .b_rsp_valid (b_rsp_valid),
    .b_rdata     (b_rdata),
    .bus         (req_bus.requester)
  );

  // sequencer on the chip pins
  sram_controller i_controller (
    .clk       (clk),
    .reset     (reset),
    .bus       (req_bus.server),
    .sram_addr (sram_addr),
    .sram_data (sram_data),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n)
  );

endmodule

/* sim/async_sram_model.sv */
module async_sram_model (
  input  logic            ce_n,
  input  logic            we_n,
  input  logic            oe_n,
  input  sram_pkg::addr_t addr,
  inout  sram_pkg::data_t data
);
  timeunit 1ns;
  timeprecision 1ps;

  // full word array, left unknown like a chip after power up
  sram_pkg::data_t mem [0:(1 << sram_pkg::addr_bits) - 1];

  // output enabled only for a read
  // a low we_n turns the chip outputs off
  assign data = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;

  // the word is taken as we_n goes back high
  always @(posedge we_n) begin
    if (!ce_n) begin
      mem[addr] = data;
    end
  end

endmodule

/* sim/sram_subsystem_checker.sv */
module sram_subsystem_checker (
  input logic                  clk,
  input logic                  reset,
  input sram_pkg::ctrl_state_t state,
  input logic                  rsp_valid,
  input sram_pkg::addr_t       sram_addr,
  input logic                  sram_we_n,
  input logic                  sram_oe_n
);
  timeunit 1ns;
  timeprecision 1ps;

  // chip never sees a read and a write strobe together
  strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
    sram_we_n || sram_oe_n)
    else $error("we_n and oe_n low at the same time");

  // strobes move on falling edges, so sample there
  addr_stable: assert property (@(negedge clk) disable iff (reset)
    (!sram_we_n || !sram_oe_n) |-> $stable(sram_addr))
    else $error("sram_addr changed under an active strobe");

  we_one_cycle: assert property (@(negedge clk) disable iff (reset)
    $fell(sram_we_n) |=> $rose(sram_we_n))
    else $error("we_n low for other than one cycle");

  oe_one_cycle: assert property (@(negedge clk) disable iff (reset)
    $fell(sram_oe_n) |=> $rose(sram_oe_n))
    else $error("oe_n low for other than one cycle");

  // st_reading is the cycle after a read acceptance
  rsp_after_read: assert property (@(posedge clk) disable iff (reset)
    (state == sram_pkg::st_reading) |-> ##2 rsp_valid)
    else $error("no rsp_valid two edges after a read acceptance");

  rsp_only_for_read: assert property (@(posedge clk) disable iff (reset)
    rsp_valid |-> $past(state, 2) == sram_pkg::st_reading)
    else $error("rsp_valid without a read acceptance before it");

endmodule

/* sim/sram_subsystem_tb.sv */
module sram_subsystem_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // requests over all tests, sizes the watchdog
  localparam int total_requests = 16 + 4 + 20 + 80;
  localparam int mix_len = 40;

  logic              clk;
  logic              reset;
  logic              a_req_valid;
  logic              a_write;
  sram_pkg::addr_t   a_addr;
  sram_pkg::data_t   a_wdata;
  logic              a_req_ready;
  logic              a_rsp_valid;
  sram_pkg::data_t   a_rdata;
  logic              b_req_valid;
  logic              b_write;
  sram_pkg::addr_t   b_addr;
  sram_pkg::data_t   b_wdata;
  logic              b_req_ready;
  logic              b_rsp_valid;
  sram_pkg::data_t   b_rdata;
  sram_pkg::addr_t   sram_addr;
  wire sram_pkg::data_t sram_data;
  logic              sram_we_n;
  logic              sram_oe_n;

  // scoreboard of written words, and per client reads in flight
  sram_pkg::data_t   sb [sram_pkg::addr_t];
  sram_pkg::data_t   exp_data [2][$];
  int unsigned       exp_cycle [2][$];
  sram_pkg::client_t grant_log [$];
  sram_pkg::addr_t   addr_list [8];
  logic              mix_wr [2][mix_len];
  sram_pkg::addr_t   mix_addr [2][mix_len];
  sram_pkg::data_t   mix_data [2][mix_len];
  int                mix_gap [2][mix_len];
  int unsigned       cycle = 0;
  int                errors = 0;
  string             test_name;

  sram_subsystem i_dut (.*);

  // chip enable tied low on the board
  async_sram_model i_sram (
    .ce_n (1'b0),
    .we_n (sram_we_n),
    .oe_n (sram_oe_n),
    .addr (sram_addr),
    .data (sram_data)
  );

  bind sram_controller sram_subsystem_checker i_checker (
    .clk       (clk),
    .reset     (reset),
    .state     (state),
    .rsp_valid (rsp_valid_q),
    .sram_addr (sram_addr),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic check_data(input string test, input sram_pkg::data_t exp,
                            input sram_pkg::data_t act);
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %h, actual %h", test, exp, act);
    end
  endtask

  task automatic check_bit(input string test, input string what, input logic exp,
                           input logic act);
    if (act !== exp) begin
      errors++;
      $display("error %s: %s expected %b, actual %b", test, what, exp, act);
    end
  endtask

  task automatic check_client(input string test, input sram_pkg::client_t exp,
                              input sram_pkg::client_t act);
    if (act !== exp) begin
      errors++;
      $display("error %s: grant expected %s, actual %s", test, exp.name(), act.name());
    end
  endtask

  // unwritten words read back unknown
  function automatic sram_pkg::data_t expected_word(input sram_pkg::addr_t addr);
    if (sb.exists(addr)) begin
      return sb[addr];
    end
    return 'x;
  endfunction

  task automatic drive_client(input sram_pkg::client_t c, input logic valid, input logic wr,
                              input sram_pkg::addr_t addr, input sram_pkg::data_t data);
    if (c == sram_pkg::client_a) begin
      a_req_valid = valid;
      a_write = wr;
      a_addr = addr;
      a_wdata = data;
    end else begin
      b_req_valid = valid;
      b_write = wr;
      b_addr = addr;
      b_wdata = data;
    end
  endtask

  task automatic release_client(input sram_pkg::client_t c);
    drive_client(c, 1'b0, 1'b0, '0, '0);
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  // valid stays high so back to back requests keep it asserted
  task automatic do_request(input sram_pkg::client_t c, input logic wr,
                            input sram_pkg::addr_t addr, input sram_pkg::data_t data);
    logic accepted;
    accepted = 1'b0;
    drive_client(c, 1'b1, wr, addr, data);
    while (!accepted) begin
      // ready is settled here and holds until the rising edge
      #1;
      accepted = (c == sram_pkg::client_a) ? a_req_ready : b_req_ready;
      if (accepted) begin
        @(posedge clk);
        grant_log.push_back(c);
        if (wr) begin
          sb[addr] = data;
        end else begin
          exp_data[c].push_back(expected_word(addr));
          exp_cycle[c].push_back(cycle);
        end
      end
      @(negedge clk);
    end
  endtask

  // pairs each response strobe with the oldest read of that client
  task automatic watch_responses(input sram_pkg::client_t c);
    logic            valid;
    sram_pkg::data_t data;
    forever begin
      @(negedge clk);
      valid = (c == sram_pkg::client_a) ? a_rsp_valid : b_rsp_valid;
      data = (c == sram_pkg::client_a) ? a_rdata : b_rdata;
      if (valid) begin
        if (exp_data[c].size() == 0) begin
          errors++;
          $display("%s: client %s got a read response it never asked for",
                   test_name, c.name());
        end else begin
          check_data(test_name, exp_data[c].pop_front(), data);
          void'(exp_cycle[c].pop_front());
        end
      end else if (exp_cycle[c].size() != 0 && cycle - exp_cycle[c][0] > 4) begin
        errors++;
        $display("%s: client %s got no read response within 4 cycles", test_name, c.name());
        void'(exp_data[c].pop_front());
        void'(exp_cycle[c].pop_front());
      end
    end
  endtask

  initial watch_responses(sram_pkg::client_a);
  initial watch_responses(sram_pkg::client_b);

  task automatic wait_drain();
    for (int i = 0; i < 8; i++) begin
      if (exp_data[0].size() == 0 && exp_data[1].size() == 0) begin
        break;
      end
      @(negedge clk);
    end
  endtask

  task automatic check_idle_levels();
    check_bit(test_name, "sram_we_n", 1'b1, sram_we_n);
    check_bit(test_name, "sram_oe_n", 1'b1, sram_oe_n);
    check_bit(test_name, "a_rsp_valid", 1'b0, a_rsp_valid);
    check_bit(test_name, "b_rsp_valid", 1'b0, b_rsp_valid);
    check_bit(test_name, "a_req_ready", 1'b1, a_req_ready);
    check_bit(test_name, "b_req_ready", 1'b1, b_req_ready);
  endtask

  task automatic reset_state();
    test_name = "reset_state";
    repeat (5) @(negedge clk);
    check_idle_levels();
    repeat (5) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_idle_levels();
  endtask

  task automatic single_client_write_read();
    test_name = "single_client_write_read";
    for (int i = 0; i < 8; i++) begin
      addr_list[i] = sram_pkg::addr_t'($urandom);
      do_request(sram_pkg::client_a, 1'b1, addr_list[i], sram_pkg::data_t'($urandom));
    end
    for (int i = 0; i < 8; i++) begin
      do_request(sram_pkg::client_a, 1'b0, addr_list[i], '0);
    end
    release_client(sram_pkg::client_a);
    wait_drain();
  endtask

  task automatic cross_client_coherence();
    sram_pkg::addr_t addr;
    test_name = "cross_client_coherence";
    addr = sram_pkg::addr_t'($urandom);
    do_request(sram_pkg::client_b, 1'b1, addr, sram_pkg::data_t'($urandom));
    release_client(sram_pkg::client_b);
    do_request(sram_pkg::client_a, 1'b0, addr, '0);
    do_request(sram_pkg::client_a, 1'b1, addr, sram_pkg::data_t'($urandom));
    release_client(sram_pkg::client_a);
    do_request(sram_pkg::client_b, 1'b0, addr, '0);
    release_client(sram_pkg::client_b);
    wait_drain();
  endtask

  task automatic read_burst(input sram_pkg::client_t c);
    for (int i = 0; i < 10; i++) begin
      do_request(c, 1'b0, addr_list[(i + int'(c)) % 8], '0);
    end
    release_client(c);
  endtask

  task automatic contention_round_robin();
    test_name = "contention_round_robin";
    grant_log.delete();
    fork
      read_burst(sram_pkg::client_a);
      read_burst(sram_pkg::client_b);
    join
    wait_drain();
    // every grant after the first goes to the other client
    for (int i = 1; i < grant_log.size(); i++) begin
      check_client(test_name, sram_pkg::client_t'(!grant_log[i - 1]), grant_log[i]);
    end
  endtask

  task automatic mix_client(input sram_pkg::client_t c);
    for (int i = 0; i < mix_len; i++) begin
      do_request(c, mix_wr[c][i], mix_addr[c][i], mix_data[c][i]);
      if (mix_gap[c][i] > 0) begin
        release_client(c);
        repeat (mix_gap[c][i]) @(negedge clk);
      end
    end
    release_client(c);
  endtask

  task automatic random_mix();
    test_name = "random_mix";
    // drawn up front so the sequence does not hang on thread order
    for (int c = 0; c < 2; c++) begin
      for (int i = 0; i < mix_len; i++) begin
        mix_wr[c][i] = ($urandom_range(1) == 1);
        mix_addr[c][i] = sram_pkg::addr_t'(20'h00100 + $urandom_range(15));
        mix_data[c][i] = sram_pkg::data_t'($urandom);
        mix_gap[c][i] = $urandom_range(3);
      end
    end
    fork
      mix_client(sram_pkg::client_a);
      mix_client(sram_pkg::client_b);
    join
    wait_drain();
  endtask

  // watchdog, 8 cycles per request plus reset
  initial begin
    #((total_requests * 8 + 10) * 4);
    $display("timeout: the tests did not finish in the expected time");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h188b_ce83));
    clk = 1'b0;
    reset = 1'b1;
    release_client(sram_pkg::client_a);
    release_client(sram_pkg::client_b);
    reset_state();
    single_client_write_read();
    cross_client_coherence();
    contention_round_robin();
    random_mix();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* sim.f */
hdl/sram_pkg.sv
hdl/sram_req_if.sv
hdl/sram_arbiter.sv
hdl/sram_controller.sv
hdl/sram_subsystem.sv
sim/async_sram_model.sv
sim/sram_subsystem_checker.sv
sim/sram_subsystem_tb.sv
